// ==== project.f ====
+incdir+include
hw/ipv4_csum_pkg.sv
hw/csum_req_if.sv
hw/ipv4_checksum_update.sv
hw/ipv4_header_sum.sv
hw/ipv4_rewrite_commit.sv
hw/ipv4_csum_rewriter.sv
tests/tb_clock_gen.sv
tests/ipv4_csum_assert.sv
tests/tb_ipv4_csum_rewriter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator, the log decides pass or fail
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f \
    --top-module tb_ipv4_csum_rewriter -o sim_tb

# Bound assertion failures are counted by the testbench, so the run continues past them
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tests/tb_ipv4_csum_rewriter.sv ====
//////////////////////////////
// Random headers from a fixed LFSR seed, stops at the first error
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ipv4_csum_settings.svh"

module tb_ipv4_csum_rewriter;

    import ipv4_csum_pkg::*;

    localparam int CLK_PERIOD_NS   = 100;
    localparam int DRIVE_DLY_NS    = 2;
    localparam int ACK_LIMIT       = 8;
    localparam int POLL_LIMIT      = 64;
    localparam int N_RANDOM        = 200;
    // Register test, valid, corrupt, seven bad indices, busy test, random series
    localparam int N_OPS           = 11 + N_RANDOM;
    localparam int OP_BOUND_CYCLES = 400;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADDR_W-1:0] wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;

    logic [31:0] lfsr = 32'hd6e8a2a9;
    logic [31:0] exp_q[$];
    logic [31:0] cmp_exp;
    logic        check_pending = 1'b0;

    tb_clock_gen clk_gen (.clk(clk));

    ipv4_csum_rewriter UUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    bind ipv4_rewrite_commit ipv4_csum_assert u_assert (
        .clk(clk), .rst(rst), .wb_ack(wb_ack), .busy(busy), .sum_done(sum_done),
        .upd_seen(upd_seen), .old_ok(old_ok), .upd_latched(upd_latched),
        .fresh_checksum(fresh_checksum)
    );

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    task automatic rand_bits(input int n, output logic [15:0] v);
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[0];
            lfsr = lfsr >> 1;
            if (fb) begin
                lfsr = lfsr ^ 32'h80200003;
            end
            v = {v[14:0], fb};
        end
    endtask

    // End-around carry sum of the header, optionally with the checksum word as zero
    function automatic logic [15:0] fold_sum(input hdr_words_t h, input logic skip_csum);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            if (!(skip_csum && i == `IPV4_CSUM_WORD)) begin
                s = s + {16'b0, h[i]};
            end
        end
        s = {16'b0, s[15:0]} + {16'b0, s[31:16]};
        s = {16'b0, s[15:0]} + {16'b0, s[31:16]};
        return s[15:0];
    endfunction

    function automatic logic [15:0] ref_checksum(input hdr_words_t h);
        return ~fold_sum(h, 1'b1);
    endfunction

    // One classic cycle, inputs change just after the rising edge
    // The request stays up through the ack cycle, as for a master that samples ack on the edge
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        @(posedge clk);
        #(DRIVE_DLY_NS);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(posedge clk);
            #(DRIVE_DLY_NS);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            $display("No Wishbone ack for address %0d at %0t", adr, $time);
            stop_run();
        end else begin
            rdat = wb_dat_r;
            @(posedge clk);
            #(DRIVE_DLY_NS);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            assert (!wb_ack) else begin
                $display("Address %0d was acked twice at %0t", adr, $time);
                stop_run();
            end
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    // Expected value goes to the compare process before the read starts
    task automatic check_read(input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] unused;
        exp_q.push_back(exp);
        check_pending = 1'b1;
        wb_access(1'b0, adr, '0, unused);
    endtask

    task automatic check_headers(input hdr_words_t h);
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            check_read(4'(i), {16'b0, h[i]});
        end
    endtask

    task automatic load_header(input hdr_words_t h);
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            wb_write(4'(i), {16'b0, h[i]});
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int polls;
        polls = 0;
        do begin
            wb_access(1'b0, REG_STATUS, '0, st);
            polls++;
        end while (!(st[1] && !st[0]) && polls < POLL_LIMIT);
        if (!(st[1] && !st[0])) begin
            $display("Rewrite never reported done, status %h", st);
            stop_run();
        end
    endtask

    task automatic pick_index(output logic [3:0] idx);
        logic [15:0] r;
        do begin
            rand_bits(4, r);
        end while (r >= `IPV4_HDR_WORDS || r == `IPV4_CSUM_WORD);
        idx = r[3:0];
    endtask

    // Random header with a correct checksum
    task automatic make_header(output hdr_words_t h);
        logic [15:0] w;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            rand_bits(16, w);
            h[i] = w;
        end
        h[`IPV4_CSUM_WORD] = ref_checksum(h);
    endtask

    // Full rewrite, with a corrupted checksum or with writes issued while busy
    task automatic run_rewrite(input logic corrupt, input logic disturb);
        hdr_words_t  h;
        hdr_words_t  exp_h;
        logic [3:0]  idx;
        logic [3:0]  other_idx;
        logic [15:0] newv;
        logic [15:0] r;
        logic [15:0] csum;
        logic        ok;
        make_header(h);
        pick_index(idx);
        rand_bits(16, newv);
        if (corrupt) begin
            rand_bits(16, r);
            h[`IPV4_CSUM_WORD] = h[`IPV4_CSUM_WORD] ^ ((r == 16'h0) ? 16'h0001 : r);
        end
        ok = (fold_sum(h, 1'b0) == 16'hffff);
        exp_h = h;
        exp_h[idx] = newv;
        csum = ref_checksum(exp_h);
        exp_h[`IPV4_CSUM_WORD] = csum;
        load_header(h);
        wb_write(REG_NEW_FIELD, {16'b0, newv});
        wb_write(REG_CTRL, 32'h100 | {28'b0, idx});
        if (disturb) begin
            // Both land inside the 12 cycle busy window and must be dropped
            // A different word keeps the write-back from hiding either of them
            do begin
                pick_index(other_idx);
            end while (other_idx == idx);
            rand_bits(16, r);
            wb_write(other_idx, {16'b0, r});
            wb_write(REG_CTRL, 32'h100 | {28'b0, other_idx});
        end
        wait_done();
        check_read(REG_STATUS, {27'b0, 1'b0, !ok, ok, 1'b1, 1'b0});
        check_read(REG_RESULT, {16'b0, csum});
        check_headers(exp_h);
    endtask

    // Read data is compared in the middle of the ack cycle
    always @(negedge clk) begin
        if (wb_ack && check_pending) begin
            check_pending = 1'b0;
            cmp_exp = exp_q.pop_front();
            assert (wb_dat_r == cmp_exp) else begin
                $display("** Error at %0t: address %0d read %h, expected %h",
                         $time, wb_adr, wb_dat_r, cmp_exp);
                stop_run();
            end
        end
    end

    // A bound assertion that fired is seen at the next falling edge
    always @(negedge clk) begin
        if (UUT.u_commit.u_assert.fail_count != 0) begin
            $display("Bound assertion failed before %0t", $time);
            stop_run();
        end
    end

    initial begin
        #(N_OPS * OP_BOUND_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d operations worth of cycles", N_OPS);
        stop_run();
    end

    initial begin
        hdr_words_t  cur;
        logic [15:0] w;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (8) @(posedge clk);
        #(DRIVE_DLY_NS);
        rst = 1'b0;

        // Register access
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            rand_bits(16, w);
            cur[i] = w;
        end
        load_header(cur);
        check_headers(cur);

        run_rewrite(1'b0, 1'b0);
        run_rewrite(1'b1, 1'b0);

        // Bad index, index 5 and 10 to 15 leave the header alone
        make_header(cur);
        load_header(cur);
        for (int i = 5; i < 16; i++) begin
            if (i == 5 || i >= 10) begin
                wb_write(REG_CTRL, 32'h100 | 32'(i));
                check_read(REG_STATUS, 32'h12);
                check_headers(cur);
            end
        end

        run_rewrite(1'b0, 1'b1);

        for (int n = 0; n < N_RANDOM; n++) begin
            rand_bits(1, w);
            run_rewrite(w[0], 1'b0);
        end

        assert (exp_q.size() == 0) else begin
            $display("%0d expected reads were never compared", exp_q.size());
            stop_run();
        end
        if (UUT.u_commit.u_assert.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", UUT.u_commit.u_assert.fail_count);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== tests/ipv4_csum_assert.sv ====
//////////////////////////////
// Bound into ipv4_rewrite_commit, counts its own failures
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipv4_csum_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     wb_ack,
    input logic                     busy,
    input logic                     sum_done,
    input logic                     upd_seen,
    input logic                     old_ok,
    input ipv4_csum_pkg::hdr_word_t upd_latched,
    input ipv4_csum_pkg::hdr_word_t fresh_checksum
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Every access gets a single ack pulse
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack stayed high for two cycles");
        end

    // With a valid old header the incremental and the fresh checksum agree
    csum_agree: assert property (@(posedge clk) disable iff (rst)
        (busy && sum_done && upd_seen && old_ok) |-> (upd_latched == fresh_checksum))
        else begin
            fail_count++;
            $error("incremental checksum %h differs from fresh %h", upd_latched, fresh_checksum);
        end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
//////////////////////////////
// Free-running 100 ns clock, starts low
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 50;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

// ==== hw/ipv4_csum_rewriter.sv ====
//////////////////////////////
// IPv4 field rewriter top, plain Wishbone classic slave ports
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ipv4_csum_settings.svh"

module ipv4_csum_rewriter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADDR_W-1:0] wb_adr,
    input  logic [`WB_DATA_W-1:0] wb_dat_w,
    output logic [`WB_DATA_W-1:0] wb_dat_r,
    output logic                  wb_ack
);

    import ipv4_csum_pkg::*;

    // One request bus shared by the commit block and both checksum units
    csum_req_if req_bus ();

    hdr_words_t hdr;
    logic       upd_valid;
    hdr_word_t  upd_checksum;
    logic       sum_done;
    logic       old_ok;
    hdr_word_t  fresh_checksum;

    // Register file, request launch and write-back
    ipv4_rewrite_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .req            (req_bus.commit),
        .hdr            (hdr),
        .upd_valid      (upd_valid),
        .upd_checksum   (upd_checksum),
        .sum_done       (sum_done),
        .old_ok         (old_ok),
        .fresh_checksum (fresh_checksum)
    );

    // Incremental path, done long before the summer
    ipv4_checksum_update u_update (
        .clk          (clk),
        .rst          (rst),
        .req          (req_bus.update),
        .upd_valid    (upd_valid),
        .upd_checksum (upd_checksum)
    );

    // Full pass that validates the old header and recomputes from scratch
    ipv4_header_sum u_sum (
        .clk            (clk),
        .rst            (rst),
        .req            (req_bus.summer),
        .hdr            (hdr),
        .sum_done       (sum_done),
        .old_ok         (old_ok),
        .fresh_checksum (fresh_checksum)
    );

endmodule

`default_nettype wire

// ==== hw/ipv4_rewrite_commit.sv ====
//////////////////////////////
// Wishbone classic slave, single ack cycle, no err/rty, no byte selects
// One rewrite in flight, header writes and starts ignored while busy
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ipv4_csum_settings.svh"

module ipv4_rewrite_commit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`WB_ADDR_W-1:0]     wb_adr,
    input  logic [`WB_DATA_W-1:0]     wb_dat_w,
    output logic [`WB_DATA_W-1:0]     wb_dat_r,
    output logic                      wb_ack,
    csum_req_if.commit                req,
    output ipv4_csum_pkg::hdr_words_t hdr,
    input  logic                      upd_valid,
    input  ipv4_csum_pkg::hdr_word_t  upd_checksum,
    input  logic                      sum_done,
    input  logic                      old_ok,
    input  ipv4_csum_pkg::hdr_word_t  fresh_checksum
);

    import ipv4_csum_pkg::*;

    localparam int CTRL_START_BIT = 8;

    // Register file and status
    hdr_words_t hdr_q;
    hdr_word_t  new_field_q;
    hdr_word_t  result_q;
    logic       busy;
    logic       done;
    logic       old_ok_q;
    logic       repaired;
    logic       bad_index;

    // Incremental result kept until the summer finishes
    hdr_word_t  upd_latched;
    logic       upd_seen;

    // Start seen on the ack edge, request pulse one cycle later
    logic       launch;

    logic                  access;
    logic                  wr_access;
    reg_addr_e             addr;
    logic [3:0]            ctrl_idx;
    logic                  ctrl_start;
    logic                  idx_ok;
    logic                  start_ok;
    logic                  start_bad;
    logic                  finish;
    hdr_word_t             chosen_csum;
    logic [`WB_DATA_W-1:0] rd_data;

    // A request counts only while ack is low, so each access is acked once
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_access = access && wb_we;
    assign addr      = reg_addr_e'(wb_adr);

    // Start decode, index must address a header word other than the checksum
    assign ctrl_idx   = wb_dat_w[3:0];
    assign ctrl_start = wr_access && (addr == REG_CTRL) && wb_dat_w[CTRL_START_BIT] && !busy;
    assign idx_ok     = (ctrl_idx < `IPV4_HDR_WORDS) && (ctrl_idx != `IPV4_CSUM_WORD);
    assign start_ok   = ctrl_start && idx_ok;
    assign start_bad  = ctrl_start && !idx_ok;

    // Both results are in once the summer reports, the updater is always earlier
    assign finish      = busy && sum_done && upd_seen;
    // Incremental result is trusted only when the old header was valid
    assign chosen_csum = old_ok ? upd_latched : fresh_checksum;

    assign hdr = hdr_q;

    always_comb begin
        rd_data = '0;
        case (addr)
            HDR0, HDR1, HDR2, HDR3, HDR4,
            HDR5, HDR6, HDR7, HDR8, HDR9: rd_data[15:0] = hdr_q[wb_adr];
            REG_CTRL:      rd_data[3:0]  = req.field_idx;
            REG_NEW_FIELD: rd_data[15:0] = new_field_q;
            REG_STATUS:    rd_data[4:0]  = {bad_index, repaired, old_ok_q, done, busy};
            REG_RESULT:    rd_data[15:0] = result_q;
            default:       rd_data       = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack        <= 1'b0;
            hdr_q         <= '0;
            new_field_q   <= '0;
            result_q      <= '0;
            busy          <= 1'b0;
            done          <= 1'b0;
            old_ok_q      <= 1'b0;
            repaired      <= 1'b0;
            bad_index     <= 1'b0;
            upd_seen      <= 1'b0;
            launch        <= 1'b0;
            req.req_valid <= 1'b0;
            req.field_idx <= '0;
        end else begin
            wb_ack        <= access;
            launch        <= start_ok;
            req.req_valid <= launch;

            // Plain register writes, header locked during a rewrite
            if (wr_access) begin
                case (addr)
                    HDR0, HDR1, HDR2, HDR3, HDR4,
                    HDR5, HDR6, HDR7, HDR8, HDR9: begin
                        if (!busy) begin
                            hdr_q[wb_adr] <= wb_dat_w[15:0];
                        end
                    end
                    REG_NEW_FIELD: new_field_q <= wb_dat_w[15:0];
                    default: ;
                endcase
            end

            if (start_ok) begin
                busy          <= 1'b1;
                done          <= 1'b0;
                old_ok_q      <= 1'b0;
                repaired      <= 1'b0;
                bad_index     <= 1'b0;
                upd_seen      <= 1'b0;
                req.field_idx <= ctrl_idx;
            end

            // Rejected start finishes at once and touches no header word
            if (start_bad) begin
                done      <= 1'b1;
                old_ok_q  <= 1'b0;
                repaired  <= 1'b0;
                bad_index <= 1'b1;
            end

            if (upd_valid) begin
                upd_seen <= 1'b1;
            end

            // Write-back of the new field and the chosen checksum
            if (finish) begin
                hdr_q[req.field_idx]   <= req.new_field;
                hdr_q[`IPV4_CSUM_WORD] <= chosen_csum;
                result_q               <= chosen_csum;
                old_ok_q               <= old_ok;
                repaired               <= !old_ok;
                busy                   <= 1'b0;
                done                   <= 1'b1;
                upd_seen               <= 1'b0;
            end
        end
    end

    // Request payload, loaded from the stored header when the start is acked
    always_ff @(posedge clk) begin
        if (start_ok) begin
            req.new_field    <= new_field_q;
            req.old_field    <= hdr_q[ctrl_idx];
            req.old_checksum <= hdr_q[`IPV4_CSUM_WORD];
        end
        if (upd_valid) begin
            upd_latched <= upd_checksum;
        end
        // Read data is captured with the ack and is valid while ack is high
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipv4_header_sum.sv ====
//////////////////////////////
// One word per cycle, sum_done IPV4_HDR_WORDS+1 cycles after req_valid
// Header must stay stable while the pass runs
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ipv4_csum_settings.svh"

module ipv4_header_sum (
    input  logic                     clk,
    input  logic                     rst,
    csum_req_if.summer               req,
    input  ipv4_csum_pkg::hdr_words_t hdr,
    output logic                     sum_done,
    output logic                     old_ok,
    output ipv4_csum_pkg::hdr_word_t  fresh_checksum
);

    import ipv4_csum_pkg::*;

    localparam int CNT_W = $clog2(`IPV4_HDR_WORDS);

    sum_state_e state;
    logic [CNT_W-1:0] cnt;

    // Request fields are held for the whole pass
    logic [3:0] idx_q;
    hdr_word_t  new_q;

    // Old header sum and rewritten header sum
    hdr_word_t acc_old;
    hdr_word_t acc_new;

    hdr_word_t word_old;
    hdr_word_t word_new;
    hdr_word_t acc_old_nxt;
    hdr_word_t acc_new_nxt;

    // Word as stored, and the same word as it will be after the rewrite
    // The checksum word counts as zero in the fresh sum
    always_comb begin
        word_old = hdr[cnt];
        if (cnt == idx_q) begin
            word_new = new_q;
        end else if (cnt == `IPV4_CSUM_WORD) begin
            word_new = '0;
        end else begin
            word_new = word_old;
        end
        acc_old_nxt = oc_add(acc_old, word_old);
        acc_new_nxt = oc_add(acc_new, word_new);
    end

    assign sum_done = (state == SUM_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SUM_IDLE;
            cnt   <= '0;
        end else if (req.req_valid) begin
            // A request always restarts the pass from word zero
            state <= SUM_RUN;
            cnt   <= '0;
        end else begin
            case (state)
                SUM_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`IPV4_HDR_WORDS - 1)) begin
                        state <= SUM_DONE;
                    end
                end
                SUM_DONE: state <= SUM_IDLE;
                default:  state <= SUM_IDLE;
            endcase
        end
    end

    // Accumulators and results, results held until the next request
    always_ff @(posedge clk) begin
        if (req.req_valid) begin
            idx_q   <= req.field_idx;
            new_q   <= req.new_field;
            acc_old <= '0;
            acc_new <= '0;
        end else if (state == SUM_RUN) begin
            acc_old <= acc_old_nxt;
            acc_new <= acc_new_nxt;
            if (cnt == CNT_W'(`IPV4_HDR_WORDS - 1)) begin
                // A valid header sums to all ones including its checksum
                old_ok         <= (acc_old_nxt == 16'hffff);
                fresh_checksum <= ~acc_new_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipv4_checksum_update.sv ====
//////////////////////////////
// RFC 1624 eqn 3 updater, result two cycles after req_valid
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_update (
    input  logic                    clk,
    input  logic                    rst,
    csum_req_if.update              req,
    output logic                    upd_valid,
    output ipv4_csum_pkg::hdr_word_t upd_checksum
);

    import ipv4_csum_pkg::*;

    // Stage one holds ~HC + ~m and carries m' along
    logic      s1_valid;
    hdr_word_t s1_sum;
    hdr_word_t s1_new;

    // Valid bits travel with the data through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            upd_valid <= 1'b0;
        end else begin
            s1_valid  <= req.req_valid;
            upd_valid <= s1_valid;
        end
    end

    // Stage one, sum of the inverted old checksum and the inverted old field
    // A new request may enter here on every cycle
    always_ff @(posedge clk) begin
        if (req.req_valid) begin
            s1_sum <= oc_add(~req.old_checksum, ~req.old_field);
            s1_new <= req.new_field;
        end
    end

    // Stage two adds the new field and inverts
    // HC' = ~(~HC + ~m + m') has no minus-zero problem, unlike HC - ~m - m'
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            upd_checksum <= ~oc_add(s1_sum, s1_new);
        end
    end

endmodule

`default_nettype wire

// ==== hw/csum_req_if.sv ====
//////////////////////////////
// One rewrite request, valid for the single cycle of req_valid
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface csum_req_if;

    import ipv4_csum_pkg::*;

    // Pulse that launches both checksum units
    logic       req_valid;
    // Header word being replaced and its old and new contents
    logic [3:0] field_idx;
    hdr_word_t  old_field;
    hdr_word_t  new_field;
    // Checksum word as it stood before the rewrite
    hdr_word_t  old_checksum;

    modport commit (
        output req_valid, field_idx, old_field, new_field, old_checksum
    );

    // Incremental updater works only from the old and new values
    modport update (
        input req_valid, old_field, new_field, old_checksum
    );

    // Summer reads the header itself and only needs the substitution
    modport summer (
        input req_valid, field_idx, new_field
    );

endinterface

`default_nettype wire

// ==== hw/ipv4_csum_pkg.sv ====
//////////////////////////////
// Header types and encodings shared by the rewriter blocks
//////////////////////////////

`default_nettype none

`include "ipv4_csum_settings.svh"

package ipv4_csum_pkg;

    // One 16-bit header word and the whole header as a packed array
    typedef logic [15:0] hdr_word_t;
    typedef hdr_word_t [`IPV4_HDR_WORDS-1:0] hdr_words_t;

    // Wishbone word addresses of the register file
    typedef enum logic [`WB_ADDR_W-1:0] {
        HDR0          = 4'd0,
        HDR1          = 4'd1,
        HDR2          = 4'd2,
        HDR3          = 4'd3,
        HDR4          = 4'd4,
        HDR5          = 4'd5,
        HDR6          = 4'd6,
        HDR7          = 4'd7,
        HDR8          = 4'd8,
        HDR9          = 4'd9,
        REG_CTRL      = 4'd10,
        REG_NEW_FIELD = 4'd11,
        REG_STATUS    = 4'd12,
        REG_RESULT    = 4'd13
    } reg_addr_e;

    // Header summer FSM states
    typedef enum logic [1:0] {
        SUM_IDLE,
        SUM_RUN,
        SUM_DONE
    } sum_state_e;

    // One's-complement add of two words with a single end-around carry
    // Two operands can never carry twice, so one fold is enough
    function automatic hdr_word_t oc_add(input hdr_word_t a, input hdr_word_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'b0, s[16]};
    endfunction

endpackage

`default_nettype wire

// ==== include/ipv4_csum_settings.svh ====
//////////////////////////////
// Fixed IPv4 header without options, 16-bit words
// Wishbone data is 32 bits wide, only the low 16 bits are stored
//////////////////////////////

`ifndef IPV4_CSUM_SETTINGS_SVH
`define IPV4_CSUM_SETTINGS_SVH

// Twenty byte header as 16-bit words
`define IPV4_HDR_WORDS 10

// Word that carries the header checksum
`define IPV4_CSUM_WORD 5

// Wishbone word address and data widths
`define WB_ADDR_W 4
`define WB_DATA_W 32

`endif
